/* design/rx_defines.svh */
// receive bridge widths and depths shared by the packages and RTL modules
`ifndef RX_DEFINES_SVH
`define RX_DEFINES_SVH

// one I or Q component of an antenna sample
`define RX_IQ_W 16

// left shift count applied to the selected antenna
`define RX_GAIN_W 3

// DMA word towards the host
`define RX_DMA_W 64

// output FIFO address bits, 64 words deep
`define RX_FIFO_AW 6

// packet sequence number carried in header and trailer
`define RX_SN_W 6

`endif

/* design/rx_sample_pkg.sv */
// IQ sample and packed two-antenna ADC word types for the receive sample path
`default_nettype none

`include "rx_defines.svh"

package rx_sample_pkg;

    // one complex sample, I in the upper half
    typedef struct packed {
        logic [`RX_IQ_W-1:0] i;
        logic [`RX_IQ_W-1:0] q;
    } iq_sample_t;

    // packed ADC word, antenna 1 in the upper half
    typedef struct packed {
        iq_sample_t ant1;
        iq_sample_t ant0;
    } adc_word_t;

endpackage

`default_nettype wire

/* design/rx_dma_pkg.sv */
// packet metadata, DMA word and stream beat types for the receive DMA path
`default_nettype none

`include "rx_defines.svh"

package rx_dma_pkg;

    // header and trailer layout, 64 bits from the top down
    typedef struct packed {
        logic [31:0]          tsf_low;
        logic [15:0]          pkt_len;
        logic [7:0]           pkt_rate;
        logic [`RX_SN_W-1:0]  sn;
        logic                 ht_unsupport;
        logic                 fcs_ok;
    } rx_meta_t;

    // one DMA word
    // header and trailer read it as metadata, payload as bytes
    typedef union packed {
        rx_meta_t                        meta;
        logic [`RX_DMA_W/8-1:0][7:0]     bytes;
    } rx_word_u;

    // beat on the output stream
    typedef struct packed {
        rx_word_u word;
        logic     last;
    } dma_beat_t;

endpackage

`default_nettype wire

/* design/rx_sample_sel.sv */
// antenna sample selection with mute and left shift gain towards the demodulator
`timescale 1ns/1ps
`default_nettype none

`include "rx_defines.svh"

module rx_sample_sel
(
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire rx_sample_pkg::adc_word_t   adc_data,
    input  wire                             adc_valid,
    input  wire                             ant_sel,
    input  wire                             mute,
    input  wire [`RX_GAIN_W-1:0]            bb_gain,
    output rx_sample_pkg::iq_sample_t       sample,
    output logic                            sample_strobe
);
    import rx_sample_pkg::*;

    iq_sample_t ant_pick;
    iq_sample_t ant_gained;

    // antenna select, mute forces zero
    always_comb
    begin
        ant_pick = ant_sel ? adc_data.ant1 : adc_data.ant0;
        if (mute)
        begin
            ant_pick = '0;
        end
    end

    // gain as a plain shift, only the low bits survive
    always_comb
    begin
        ant_gained.i = ant_pick.i << bb_gain;
        ant_gained.q = ant_pick.q << bb_gain;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sample_strobe <= 1'b0;
        end
        else
        begin
            sample_strobe <= adc_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (adc_valid)
        begin
            sample <= ant_gained;
        end
    end

endmodule

`default_nettype wire

/* design/rx_pkt_packer.sv */
// packet packer that frames demodulated bytes into header, payload and trailer words
`timescale 1ns/1ps
`default_nettype none

`include "rx_defines.svh"

module rx_pkt_packer
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     pkt_header_valid_strobe,
    input  wire                     pkt_header_valid,
    input  wire [7:0]               pkt_rate,
    input  wire [15:0]              pkt_len,
    input  wire                     ht_unsupport,
    input  wire                     byte_in_strobe,
    input  wire [7:0]               byte_in,
    input  wire                     fcs_in_strobe,
    input  wire                     fcs_ok,
    input  wire [63:0]              tsf_runtime_val,
    output rx_dma_pkg::dma_beat_t   word_beat,
    output logic                    word_strobe
);
    import rx_dma_pkg::*;

    localparam int BYTE_IDX_W = $clog2(`RX_DMA_W / 8);

    logic                           sig_valid;
    logic                           byte_take;
    logic                           fcs_take;
    logic                           word_full;
    logic                           in_pkt;
    logic [BYTE_IDX_W-1:0]          byte_idx;
    logic [`RX_DMA_W/8-1:0][7:0]    acc_bytes;
    logic                           trailer_pend;
    logic                           fcs_q;
    logic [`RX_SN_W-1:0]            sn_cnt;
    rx_meta_t                       meta_q;
    rx_meta_t                       hdr_meta;
    rx_word_u                       nxt_word;
    logic                           nxt_last;
    logic                           nxt_strobe;

    assign sig_valid = pkt_header_valid_strobe & pkt_header_valid;
    // bytes and fcs only count inside an open packet
    assign byte_take = byte_in_strobe & in_pkt;
    assign fcs_take  = fcs_in_strobe & in_pkt;
    assign word_full = byte_take & (&byte_idx);

    always_comb
    begin
        hdr_meta              = '0;
        hdr_meta.tsf_low      = tsf_runtime_val[31:0];
        hdr_meta.pkt_len      = pkt_len;
        hdr_meta.pkt_rate     = pkt_rate;
        hdr_meta.sn           = sn_cnt;
        hdr_meta.ht_unsupport = ht_unsupport;
    end

    // word to emit next cycle
    always_comb
    begin
        nxt_word   = '0;
        nxt_last   = 1'b0;
        nxt_strobe = 1'b0;
        if (trailer_pend)
        begin
            // trailer right behind a flushed partial word
            nxt_word.meta        = meta_q;
            nxt_word.meta.fcs_ok = fcs_q;
            nxt_last             = 1'b1;
            nxt_strobe           = 1'b1;
        end
        else if (sig_valid)
        begin
            nxt_word.meta = hdr_meta;
            nxt_strobe    = 1'b1;
        end
        else if (word_full)
        begin
            nxt_word.bytes           = acc_bytes;
            nxt_word.bytes[byte_idx] = byte_in;
            nxt_strobe               = 1'b1;
        end
        else if (fcs_take)
        begin
            if (byte_idx != '0)
            begin
                // partial word, unused bytes already zero
                nxt_word.bytes = acc_bytes;
            end
            else
            begin
                nxt_word.meta        = meta_q;
                nxt_word.meta.fcs_ok = fcs_ok;
                nxt_last             = 1'b1;
            end
            nxt_strobe = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_pkt       <= 1'b0;
            byte_idx     <= '0;
            trailer_pend <= 1'b0;
            sn_cnt       <= '0;
            word_strobe  <= 1'b0;
        end
        else
        begin
            word_strobe  <= nxt_strobe;
            trailer_pend <= fcs_take & (byte_idx != '0);
            if (sig_valid)
            begin
                in_pkt   <= 1'b1;
                byte_idx <= '0;
            end
            else if (fcs_take)
            begin
                in_pkt   <= 1'b0;
                byte_idx <= '0;
            end
            else if (byte_take)
            begin
                byte_idx <= byte_idx + 1'b1;
            end
            // sequence number wraps, one step per trailer
            if (nxt_strobe && nxt_last)
            begin
                sn_cnt <= sn_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        word_beat.word <= nxt_word;
        word_beat.last <= nxt_last;
        if (sig_valid)
        begin
            meta_q <= hdr_meta;
        end
        if (fcs_take)
        begin
            fcs_q <= fcs_ok;
        end
        if (sig_valid || fcs_take || word_full)
        begin
            acc_bytes <= '0;
        end
        else if (byte_take)
        begin
            acc_bytes[byte_idx] <= byte_in;
        end
    end

endmodule

`default_nettype wire

/* design/rx_dma_stream.sv */
// output word FIFO driving the valid/ready DMA stream and the receive interrupt
`timescale 1ns/1ps
`default_nettype none

`include "rx_defines.svh"

module rx_dma_stream
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire rx_dma_pkg::dma_beat_t  word_beat,
    input  wire                         word_strobe,
    input  wire                         m_axis_tready,
    output rx_dma_pkg::dma_beat_t       m_axis_beat,
    output logic                        m_axis_tvalid,
    output logic                        rx_pkt_intr,
    output logic                        rx_overflow
);
    import rx_dma_pkg::*;

    localparam int DEPTH = 1 << `RX_FIFO_AW;

    dma_beat_t              fifo_mem [DEPTH];
    logic [`RX_FIFO_AW:0]   wr_ptr;
    logic [`RX_FIFO_AW:0]   rd_ptr;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   push;
    logic                   pop;

    // extra pointer bit tells full from empty
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[`RX_FIFO_AW] != rd_ptr[`RX_FIFO_AW]) &&
                        (wr_ptr[`RX_FIFO_AW-1:0] == rd_ptr[`RX_FIFO_AW-1:0]);

    assign push = word_strobe & ~fifo_full;
    assign pop  = m_axis_tvalid & m_axis_tready;

    // first word falls through to the stream port
    assign m_axis_tvalid = ~fifo_empty;
    assign m_axis_beat   = fifo_mem[rd_ptr[`RX_FIFO_AW-1:0]];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_mem[wr_ptr[`RX_FIFO_AW-1:0]] <= word_beat;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rx_pkt_intr <= 1'b0;
            rx_overflow <= 1'b0;
        end
        else
        begin
            // packet handed over once its last beat is taken
            rx_pkt_intr <= pop & m_axis_beat.last;
            // word lost on a full FIFO, flag stays until reset
            if (word_strobe && fifo_full)
            begin
                rx_overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/rx_intf.sv */
// receive bridge top joining sample selection, packet packer and DMA stream
`timescale 1ns/1ps
`default_nettype none

`include "rx_defines.svh"

module rx_intf
(
    input  wire                             clk,
    input  wire                             rst_n,

    // ADC side
    input  wire rx_sample_pkg::adc_word_t   adc_data,
    input  wire                             adc_valid,

    // configuration levels
    input  wire                             ant_sel,
    input  wire                             mute,
    input  wire [`RX_GAIN_W-1:0]            bb_gain,

    // to the demodulator
    output rx_sample_pkg::iq_sample_t       sample,
    output logic                            sample_strobe,

    // from the demodulator
    input  wire                             pkt_header_valid_strobe,
    input  wire                             pkt_header_valid,
    input  wire [7:0]                       pkt_rate,
    input  wire [15:0]                      pkt_len,
    input  wire                             ht_unsupport,
    input  wire                             byte_in_strobe,
    input  wire [7:0]                       byte_in,
    input  wire                             fcs_in_strobe,
    input  wire                             fcs_ok,
    input  wire [63:0]                      tsf_runtime_val,

    // DMA stream and status
    output rx_dma_pkg::dma_beat_t           m_axis_beat,
    output logic                            m_axis_tvalid,
    input  wire                             m_axis_tready,
    output logic                            rx_pkt_intr,
    output logic                            rx_overflow
);
    import rx_dma_pkg::*;

    dma_beat_t  word_beat;
    logic       word_strobe;

    rx_sample_sel u_sample_sel (
        .clk           (clk),
        .rst_n         (rst_n),
        .adc_data      (adc_data),
        .adc_valid     (adc_valid),
        .ant_sel       (ant_sel),
        .mute          (mute),
        .bb_gain       (bb_gain),
        .sample        (sample),
        .sample_strobe (sample_strobe)
    );

    rx_pkt_packer u_pkt_packer (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .pkt_header_valid_strobe (pkt_header_valid_strobe),
        .pkt_header_valid        (pkt_header_valid),
        .pkt_rate                (pkt_rate),
        .pkt_len                 (pkt_len),
        .ht_unsupport            (ht_unsupport),
        .byte_in_strobe          (byte_in_strobe),
        .byte_in                 (byte_in),
        .fcs_in_strobe           (fcs_in_strobe),
        .fcs_ok                  (fcs_ok),
        .tsf_runtime_val         (tsf_runtime_val),
        .word_beat               (word_beat),
        .word_strobe             (word_strobe)
    );

    rx_dma_stream u_dma_stream (
        .clk           (clk),
        .rst_n         (rst_n),
        .word_beat     (word_beat),
        .word_strobe   (word_strobe),
        .m_axis_tready (m_axis_tready),
        .m_axis_beat   (m_axis_beat),
        .m_axis_tvalid (m_axis_tvalid),
        .rx_pkt_intr   (rx_pkt_intr),
        .rx_overflow   (rx_overflow)
    );

endmodule

`default_nettype wire

/* tb/rx_intf_assertions.sv */
// stream port assertions for the receive bridge, bound onto the top level
`timescale 1ns/1ps
`default_nettype none

module rx_intf_assertions
(
    input wire                          clk,
    input wire                          rst_n,
    input wire rx_dma_pkg::dma_beat_t   m_axis_beat,
    input wire                          m_axis_tvalid,
    input wire                          m_axis_tready,
    input wire                          rx_pkt_intr
);
    import rx_dma_pkg::*;

    // a stalled beat stays put until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_beat))
        else $error("stream beat or valid changed while ready was low");

    assert property (@(posedge clk) disable iff (!rst_n)
        rx_pkt_intr |=> !rx_pkt_intr)
        else $error("receive interrupt wider than one cycle");

    // interrupt only right after a last beat handshake
    assert property (@(posedge clk) disable iff (!rst_n)
        rx_pkt_intr |-> $past(m_axis_tvalid && m_axis_tready && m_axis_beat.last))
        else $error("receive interrupt without a preceding last beat handshake");

    assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(m_axis_tvalid))
        else $error("stream valid is unknown after reset");

endmodule

`default_nettype wire

/* tb/rx_intf_checker.sv */
// output monitor for the receive bridge comparing samples, beats and interrupts
`timescale 1ns/1ps
`default_nettype none

module rx_intf_checker
(
    input wire                              clk,
    input wire                              rst_n,
    input wire                              adc_valid,
    input wire rx_sample_pkg::iq_sample_t   sample,
    input wire                              sample_strobe,
    input wire rx_dma_pkg::dma_beat_t       m_axis_beat,
    input wire                              m_axis_tvalid,
    input wire                              m_axis_tready,
    input wire                              rx_pkt_intr,
    input wire                              rx_overflow
);
    import rx_sample_pkg::*;
    import rx_dma_pkg::*;

    logic [31:0]    exp_samples [$];
    logic [64:0]    exp_beats [$];
    logic [64:0]    exp_val;
    string          test_name;
    int             err_count;
    int             intr_count;
    logic           valid_d;
    logic           last_hs_d;
    logic           ovf_allowed;

    initial
    begin
        test_name   = "none";
        err_count   = 0;
        intr_count  = 0;
        valid_d     = 1'b0;
        last_hs_d   = 1'b0;
        ovf_allowed = 1'b0;
    end

    task automatic begin_test(input string name);
        test_name = name;
    endtask

    task automatic push_sample(input logic [31:0] s);
        exp_samples.push_back(s);
    endtask

    task automatic push_beat(input logic [64:0] b);
        exp_beats.push_back(b);
    endtask

    task automatic allow_overflow();
        ovf_allowed = 1'b1;
    endtask

    function automatic int pending_samples();
        return exp_samples.size();
    endfunction

    function automatic int pending_beats();
        return exp_beats.size();
    endfunction

    task automatic report_mismatch(input string what, input logic [64:0] exp,
                                   input logic [64:0] act);
        $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
        err_count++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        err_count++;
    endtask

    task automatic final_check(input int n_pkts, input logic ovf_exp);
        if (intr_count != n_pkts)
        begin
            report_mismatch("interrupt count", n_pkts, intr_count);
        end
        if (rx_overflow !== ovf_exp)
        begin
            report_mismatch("overflow flag", ovf_exp, rx_overflow);
        end
        if (exp_samples.size() != 0)
        begin
            report_error("some expected samples never appeared");
        end
        if (exp_beats.size() != 0)
        begin
            report_error("some expected beats never appeared on the stream");
        end
    endtask

    // outputs are stable mid cycle, a handshake here completes on the next edge
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (sample_strobe !== valid_d)
            begin
                report_mismatch("sample strobe", valid_d, sample_strobe);
            end
            if (sample_strobe === 1'b1)
            begin
                if (exp_samples.size() == 0)
                begin
                    report_error("sample strobe with no sample expected");
                end
                else
                begin
                    exp_val = exp_samples.pop_front();
                    if (sample !== exp_val[31:0])
                    begin
                        report_mismatch("sample", exp_val, sample);
                    end
                end
            end
            if (m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1)
            begin
                if (exp_beats.size() == 0)
                begin
                    report_error("stream beat accepted with no beat expected");
                end
                else
                begin
                    exp_val = exp_beats.pop_front();
                    if (m_axis_beat !== exp_val)
                    begin
                        report_mismatch("beat", exp_val, m_axis_beat);
                    end
                end
            end
            if (rx_pkt_intr !== last_hs_d)
            begin
                report_mismatch("interrupt", last_hs_d, rx_pkt_intr);
            end
            if (rx_pkt_intr === 1'b1)
            begin
                intr_count++;
            end
            if (rx_overflow !== 1'b0 && !ovf_allowed)
            begin
                report_error("overflow flag set while the FIFO had room");
            end
        end
        valid_d   = rst_n & adc_valid;
        last_hs_d = rst_n & m_axis_tvalid & m_axis_tready & m_axis_beat.last;
    end

endmodule

`default_nettype wire

/* tb/tb_rx_intf.sv */
// testbench for the receive bridge covering sample path, packet framing and stream
`timescale 1ns/1ps
`default_nettype none

`include "rx_defines.svh"

module tb_rx_intf;
    import rx_sample_pkg::*;
    import rx_dma_pkg::*;

    logic                   clk;
    logic                   rst_n;
    adc_word_t              adc_data;
    logic                   adc_valid;
    logic                   ant_sel;
    logic                   mute;
    logic [`RX_GAIN_W-1:0]  bb_gain;
    iq_sample_t             sample;
    logic                   sample_strobe;
    logic                   pkt_header_valid_strobe;
    logic                   pkt_header_valid;
    logic [7:0]             pkt_rate;
    logic [15:0]            pkt_len;
    logic                   ht_unsupport;
    logic                   byte_in_strobe;
    logic [7:0]             byte_in;
    logic                   fcs_in_strobe;
    logic                   fcs_ok;
    logic [63:0]            tsf_runtime_val;
    dma_beat_t              m_axis_beat;
    logic                   m_axis_tvalid;
    logic                   m_axis_tready;
    logic                   rx_pkt_intr;
    logic                   rx_overflow;

    // stream sink behaviour
    logic                   ready_random;
    logic                   ready_hold;
    logic                   ready_pick;

    logic [7:0]             pkt_bytes [$];
    logic [`RX_SN_W-1:0]    sn;
    int                     pkt_count;
    int                     timeouts;
    int                     p;
    int                     len;

    rx_intf i_dut (.*);

    rx_intf_checker u_checker (.*);

    bind rx_intf rx_intf_assertions u_assertions (
        .clk           (clk),
        .rst_n         (rst_n),
        .m_axis_beat   (m_axis_beat),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .rx_pkt_intr   (rx_pkt_intr)
    );

    always
    begin
        #4 clk = ~clk;
    end

    // ready decided mid cycle, driven after the edge
    always @(negedge clk)
    begin
        if (ready_hold)
            ready_pick = 1'b0;
        else if (ready_random)
            ready_pick = ($urandom % 4) != 0;
        else
            ready_pick = 1'b1;
    end

    always @(posedge clk)
    begin
        #1;
        m_axis_tready = ready_pick;
    end

    // expected sample, I in the upper half of each antenna
    function automatic logic [31:0] ref_sample(input logic [63:0] word, input logic sel,
                                               input logic mt, input logic [2:0] gain);
        logic [15:0] i_part;
        logic [15:0] q_part;
        i_part = sel ? word[63:48] : word[31:16];
        q_part = sel ? word[47:32] : word[15:0];
        if (mt)
        begin
            i_part = 16'h0;
            q_part = 16'h0;
        end
        i_part = i_part << gain;
        q_part = q_part << gain;
        return {i_part, q_part};
    endfunction

    function automatic logic [64:0] ref_meta_beat(input logic [31:0] tsf,
        input logic [15:0] plen, input logic [7:0] rate, input logic [5:0] seq,
        input logic ht, input logic fcs, input logic last);
        return {tsf, plen, rate, seq, ht, fcs, last};
    endfunction

    // eight bytes from first upward, byte 0 lowest, zero past the end
    function automatic logic [64:0] ref_payload_beat(input int first);
        logic [63:0] w;
        int          k;
        w = '0;
        for (k = 0; k < 8; k++)
        begin
            if (first + k < pkt_bytes.size())
            begin
                w[8*k +: 8] = pkt_bytes[first + k];
            end
        end
        return {w, 1'b0};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_samples();
        int cfg;
        int r;
        for (cfg = 0; cfg < 32; cfg++)
        begin
            ant_sel = cfg[0];
            mute    = cfg[1];
            bb_gain = cfg[4:2];
            // first word of each setting always valid
            for (r = 0; r < 4; r++)
            begin
                adc_data  = {$urandom, $urandom};
                adc_valid = (r == 0) || (($urandom % 3) != 0);
                if (adc_valid)
                begin
                    u_checker.push_sample(ref_sample(adc_data, ant_sel, mute, bb_gain));
                end
                next_cycle();
            end
        end
        adc_valid = 1'b0;
    endtask

    // one packet, only the first keep_words beats can reach the stream
    task automatic send_packet(input int nbytes, input logic fcs, input int keep_words);
        logic [64:0] beats [$];
        logic [31:0] tsf;
        logic [7:0]  rate;
        logic        ht;
        int          k;
        tsf  = $urandom;
        rate = $urandom;
        ht   = $urandom;
        pkt_bytes.delete();
        for (k = 0; k < nbytes; k++)
        begin
            pkt_bytes.push_back($urandom);
        end
        beats.push_back(ref_meta_beat(tsf, nbytes, rate, sn, ht, 1'b0, 1'b0));
        for (k = 0; k < nbytes; k += 8)
        begin
            beats.push_back(ref_payload_beat(k));
        end
        beats.push_back(ref_meta_beat(tsf, nbytes, rate, sn, ht, fcs, 1'b1));
        for (k = 0; k < beats.size() && k < keep_words; k++)
        begin
            u_checker.push_beat(beats[k]);
        end
        if (keep_words >= beats.size())
        begin
            pkt_count++;
        end
        pkt_header_valid_strobe = 1'b1;
        pkt_header_valid        = 1'b1;
        pkt_rate                = rate;
        pkt_len                 = nbytes;
        ht_unsupport            = ht;
        tsf_runtime_val         = {$urandom, tsf};
        next_cycle();
        pkt_header_valid_strobe = 1'b0;
        // header inputs and time move on after the strobe
        pkt_rate                = $urandom;
        pkt_len                 = $urandom;
        ht_unsupport            = $urandom;
        tsf_runtime_val         = {$urandom, $urandom};
        k = 0;
        while (k < nbytes)
        begin
            byte_in_strobe = ($urandom % 4) != 0;
            byte_in        = pkt_bytes[k];
            if (byte_in_strobe)
            begin
                k++;
            end
            next_cycle();
        end
        byte_in_strobe = 1'b0;
        fcs_in_strobe  = 1'b1;
        fcs_ok         = fcs;
        next_cycle();
        fcs_in_strobe  = 1'b0;
        // trailer may still be pending behind a partial word
        repeat (3) next_cycle();
        sn = sn + 1'b1;
    endtask

    // invalid header, bytes and fcs outside a packet
    task automatic send_stray();
        pkt_header_valid_strobe = 1'b1;
        pkt_header_valid        = 1'b0;
        next_cycle();
        pkt_header_valid_strobe = 1'b0;
        byte_in_strobe          = 1'b1;
        byte_in                 = $urandom;
        next_cycle();
        byte_in_strobe          = 1'b0;
        fcs_in_strobe           = 1'b1;
        next_cycle();
        fcs_in_strobe           = 1'b0;
        next_cycle();
    endtask

    task automatic wait_samples_done();
        int cycles;
        cycles = 0;
        while (u_checker.pending_samples() != 0 && cycles < 100)
        begin
            next_cycle();
            cycles++;
        end
        if (u_checker.pending_samples() != 0)
        begin
            $display("timeout: expected samples never came out of the sample port");
            timeouts++;
        end
    endtask

    function automatic logic stream_busy();
        return u_checker.pending_beats() != 0 || m_axis_tvalid ||
               u_checker.intr_count != pkt_count;
    endfunction

    task automatic wait_stream_idle(input int limit);
        int cycles;
        cycles = 0;
        while (stream_busy() && cycles < limit)
        begin
            next_cycle();
            cycles++;
        end
        if (stream_busy())
        begin
            $display("timeout: stream did not drain all packets and interrupts");
            timeouts++;
        end
    endtask

    initial
    begin
        void'($urandom(50));
        clk                     = 1'b0;
        rst_n                   = 1'b0;
        adc_data                = '0;
        adc_valid               = 1'b0;
        ant_sel                 = 1'b0;
        mute                    = 1'b0;
        bb_gain                 = '0;
        pkt_header_valid_strobe = 1'b0;
        pkt_header_valid        = 1'b0;
        pkt_rate                = '0;
        pkt_len                 = '0;
        ht_unsupport            = 1'b0;
        byte_in_strobe          = 1'b0;
        byte_in                 = '0;
        fcs_in_strobe           = 1'b0;
        fcs_ok                  = 1'b0;
        tsf_runtime_val         = '0;
        m_axis_tready           = 1'b0;
        ready_pick              = 1'b0;
        ready_random            = 1'b0;
        ready_hold              = 1'b0;
        sn                      = '0;
        pkt_count               = 0;
        timeouts                = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        u_checker.begin_test("samples");
        run_samples();
        wait_samples_done();

        u_checker.begin_test("packets");
        ready_random = 1'b1;
        for (p = 0; p < 12; p++)
        begin
            // edge lengths first, then random ones
            len = (p == 0) ? 1 : (p == 1) ? 8 : (p == 2) ? 60 : 1 + $urandom % 60;
            send_packet(len, p[0], 1000);
            if (p % 3 == 0)
            begin
                send_stray();
            end
        end
        wait_stream_idle(1000);

        u_checker.begin_test("overflow");
        u_checker.allow_overflow();
        ready_hold = 1'b1;
        next_cycle();
        send_packet(70 * 8, 1'b1, 1 << `RX_FIFO_AW);
        ready_hold = 1'b0;
        wait_stream_idle(1000);

        u_checker.final_check(pkt_count, 1'b1);
        $display("run finished with %0d errors and %0d timeouts",
                 u_checker.err_count, timeouts);
        if (u_checker.err_count == 0 && timeouts == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/rx_sample_pkg.sv
design/rx_dma_pkg.sv
design/rx_sample_sel.sv
design/rx_pkt_packer.sv
design/rx_dma_stream.sv
design/rx_intf.sv
tb/rx_intf_assertions.sv
tb/rx_intf_checker.sv
tb/tb_rx_intf.sv
